//--- Bender.yml
package:
  name: aes_key_expand

sources:
  - hw/aes_pkg.sv
  - hw/aes_sbox.sv
  - hw/aes_key_rcon.sv
  - hw/aes_key_irregular.sv
  - hw/aes_key_regular.sv
  - hw/aes_key_expand.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_aes_key_expand.sv

//--- compile.f
hw/aes_pkg.sv
hw/aes_sbox.sv
hw/aes_key_rcon.sv
hw/aes_key_irregular.sv
hw/aes_key_regular.sv
hw/aes_key_expand.sv
tests/tb_clk_gen.sv
tests/tb_aes_key_expand.sv

//--- hw/aes_key_expand.sv
////////////////////////////////////////////////////////////
// AES key expansion, one round key per step
// Rcon register, irregular word and regular XOR chains
////////////////////////////////////////////////////////////

`default_nettype none

module aes_key_expand (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  aes_pkg::key_cfg_t   cfg_i,
  input  logic                clear_i,
  input  logic                en_i,
  input  logic                out_ack_i,
  input  aes_pkg::key_state_t key_i,
  output logic                out_req_o,
  output aes_pkg::key_state_t key_o
);

  logic [7:0]     rcon;
  logic           use_rcon;
  aes_pkg::word_t irr_word;

  // Round constant and handshake
  aes_key_rcon u_aes_key_rcon (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_i      (cfg_i),
    .clear_i    (clear_i),
    .en_i       (en_i),
    .out_ack_i  (out_ack_i),
    .out_req_o  (out_req_o),
    .use_rcon_o (use_rcon),
    .rcon_o     (rcon)
  );

  // RotWord, SubWord, Rcon
  aes_key_irregular u_aes_key_irregular (
    .cfg_i      (cfg_i),
    .key_i      (key_i),
    .use_rcon_i (use_rcon),
    .rcon_i     (rcon),
    .irr_word_o (irr_word)
  );

  // XOR chains produce the next key state
  aes_key_regular u_aes_key_regular (
    .cfg_i      (cfg_i),
    .key_i      (key_i),
    .irr_word_i (irr_word),
    .key_o      (key_o)
  );

endmodule

`default_nettype wire

//--- hw/aes_key_irregular.sv
////////////////////////////////////////////////////////////
// Irregular word of one key expansion step
// RotWord input select, RotWord, SubWord and Rcon addition
////////////////////////////////////////////////////////////

`default_nettype none

module aes_key_irregular (
  input  aes_pkg::key_cfg_t   cfg_i,
  input  aes_pkg::key_state_t key_i,
  input  logic                use_rcon_i,
  input  logic [7:0]          rcon_i,
  output aes_pkg::word_t      irr_word_o
);

  aes_pkg::word_t rot_in;
  aes_pkg::word_t rot_out;
  aes_pkg::word_t sub_out;
  logic [7:0]     rcon_add;

  ////////////////////////////////////////////////////////////
  // RotWord input
  ////////////////////////////////////////////////////////////

  always_comb begin
    rot_in = key_i[3];
    unique case (cfg_i.key_len)
      aes_pkg::AES_128: begin
        // Inverse needs the previous word 3, rebuilt from words 3 and 2
        if (cfg_i.op == aes_pkg::CIPH_FWD) begin
          rot_in = key_i[3];
        end else begin
          rot_in = key_i[3] ^ key_i[2];
        end
      end
      aes_pkg::AES_256: begin
        // Forward takes the top word, inverse the top of the low half
        if (cfg_i.op == aes_pkg::CIPH_FWD) begin
          rot_in = key_i[7];
        end else begin
          rot_in = key_i[3];
        end
      end
      default: begin
        rot_in = key_i[3];
      end
    endcase
  end

  // RotWord and Rcon share one usage rule
  assign rot_out = use_rcon_i ? aes_pkg::aes_rot_word(rot_in) : rot_in;

  ////////////////////////////////////////////////////////////
  // SubWord and Rcon
  ////////////////////////////////////////////////////////////

  // One S-box per byte
  for (genvar b = 0; b < 4; b++) begin : gen_sbox
    aes_sbox u_aes_sbox (
      .data_i (rot_out[b]),
      .data_o (sub_out[b])
    );
  end

  // Rcon only touches byte 0
  assign rcon_add = use_rcon_i ? rcon_i : 8'h00;

  always_comb begin
    irr_word_o    = sub_out;
    irr_word_o[0] = sub_out[0] ^ rcon_add;
  end

endmodule

`default_nettype wire

//--- hw/aes_key_rcon.sv
////////////////////////////////////////////////////////////
// Round constant register for the key expansion
// Rcon usage decision, init and advance, output request
////////////////////////////////////////////////////////////

`default_nettype none

module aes_key_rcon (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  aes_pkg::key_cfg_t cfg_i,
  input  logic             clear_i,
  input  logic             en_i,
  input  logic             out_ack_i,
  output logic             out_req_o,
  output logic             use_rcon_o,
  output logic [7:0]       rcon_o
);

  logic [7:0] rcon_q;
  logic [7:0] rcon_d;
  logic [7:0] rcon_init;
  logic [7:0] rcon_next;
  logic       rcon_we;

  // Output is ready as soon as enabled since the S-box has no latency
  assign out_req_o = en_i;

  // Even AES-256 rounds skip Rcon and RotWord
  assign use_rcon_o = !((cfg_i.key_len == aes_pkg::AES_256) && !cfg_i.round[0]);

  // Start value depends on direction and key length
  always_comb begin
    if (cfg_i.op == aes_pkg::CIPH_FWD) begin
      rcon_init = aes_pkg::RconInitFwd;
    end else if (cfg_i.key_len == aes_pkg::AES_128) begin
      rcon_init = aes_pkg::RconInitInv128;
    end else begin
      rcon_init = aes_pkg::RconInitInv256;
    end
  end

  // Forward steps up, inverse steps down
  assign rcon_next = (cfg_i.op == aes_pkg::CIPH_FWD) ? aes_pkg::aes_mul2(rcon_q)
                                                     : aes_pkg::aes_div2(rcon_q);

  // Clear has priority over advance
  assign rcon_d  = clear_i ? rcon_init : rcon_next;
  assign rcon_we = clear_i | (use_rcon_o & en_i & out_req_o & out_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q <= 8'h00;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // From a clear on, Rcon stays a nonzero power of x through every step
  rcon_nonzero_after_clear_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (clear_i || (rcon_q != 8'h00)) |=> (rcon_q != 8'h00)
  );

  // Handshake without enable must not move Rcon
  rcon_hold_without_en_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_ack_i && !en_i && !clear_i) |=> $stable(rcon_q)
  );

endmodule

`default_nettype wire

//--- hw/aes_key_regular.sv
////////////////////////////////////////////////////////////
// Regular part of one key expansion step
// XOR chains and word shifts for AES-128 and AES-256
// in the forward and the inverse direction
////////////////////////////////////////////////////////////

`default_nettype none

module aes_key_regular (
  input  aes_pkg::key_cfg_t   cfg_i,
  input  aes_pkg::key_state_t key_i,
  input  aes_pkg::word_t      irr_word_i,
  output aes_pkg::key_state_t key_o
);

  always_comb begin
    // Half swap, also the AES-256 round 0 result
    key_o = {key_i[3:0], key_i[7:4]};

    unique case (cfg_i.key_len)

      ////////////////////////////////////////////////////////////
      // AES-128
      ////////////////////////////////////////////////////////////
      aes_pkg::AES_128: begin
        // Upper half unused, keeps a copy of the input words
        key_o[7:4] = key_i[3:0];
        key_o[0]   = irr_word_i ^ key_i[0];
        if (cfg_i.op == aes_pkg::CIPH_FWD) begin
          // Each new word builds on the one just produced
          for (int i = 1; i < 4; i++) begin
            key_o[i] = key_o[i-1] ^ key_i[i];
          end
        end else begin
          // Undo the chain from neighbouring input words
          for (int i = 1; i < 4; i++) begin
            key_o[i] = key_i[i-1] ^ key_i[i];
          end
        end
      end

      ////////////////////////////////////////////////////////////
      // AES-256
      ////////////////////////////////////////////////////////////
      aes_pkg::AES_256: begin
        if (cfg_i.round != 4'd0) begin
          if (cfg_i.op == aes_pkg::CIPH_FWD) begin
            // Old upper half moves down
            key_o[3:0] = key_i[7:4];
            // New upper half
            key_o[4] = irr_word_i ^ key_i[0];
            for (int i = 5; i < 8; i++) begin
              key_o[i] = key_o[i-1] ^ key_i[i-4];
            end
          end else begin
            // Old lower half moves up
            key_o[7:4] = key_i[3:0];
            // New lower half
            key_o[0] = irr_word_i ^ key_i[4];
            for (int i = 1; i < 4; i++) begin
              key_o[i] = key_i[i+3] ^ key_i[i+4];
            end
          end
        end
      end

      default: begin
        key_o = {key_i[3:0], key_i[7:4]};
      end
    endcase
  end

  // Key length selects the whole datapath, it must never be X
  key_len_known_a : assert final (!$isunknown(cfg_i.key_len));

endmodule

`default_nettype wire

//--- hw/aes_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions for the AES key expansion
// Cipher direction and key length encodings
// Key word, key state and configuration types
// Rcon start values and GF(2^8) byte helpers
////////////////////////////////////////////////////////////

`default_nettype none

package aes_pkg;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Cipher direction
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  // One key word, byte 0 in the low bits
  typedef logic [3:0][7:0] word_t;

  // Full key state of eight words, word 0 in the low bits
  typedef word_t [7:0] key_state_t;

  // Per-step configuration
  typedef struct packed {
    ciph_op_e   op;
    key_len_e   key_len;
    logic [3:0] round;
  } key_cfg_t;

  // Rcon value loaded on clear
  localparam logic [7:0] RconInitFwd    = 8'h01;
  localparam logic [7:0] RconInitInv128 = 8'h36;
  localparam logic [7:0] RconInitInv256 = 8'h40;

  ////////////////////////////////////////////////////////////
  // GF(2^8) helpers
  ////////////////////////////////////////////////////////////

  // Multiply by x, reduce with 0x11B
  function automatic logic [7:0] aes_mul2(input logic [7:0] in);
    return {in[6:0], 1'b0} ^ (in[7] ? 8'h1b : 8'h00);
  endfunction

  // Divide by x
  // Bit 0 set means the reduction was applied on the way up
  function automatic logic [7:0] aes_div2(input logic [7:0] in);
    return {in[0], in[7:1] ^ (in[0] ? 7'h0d : 7'h00)};
  endfunction

  // RotWord, byte 1 moves to byte 0 and byte 0 wraps to byte 3
  function automatic word_t aes_rot_word(input word_t in);
    return {in[0], in[3], in[2], in[1]};
  endfunction

endpackage

`default_nettype wire

//--- hw/aes_sbox.sv
////////////////////////////////////////////////////////////
// Forward AES S-box for a single byte
// Inverse in GF(2^8) by square-and-multiply, then affine map
////////////////////////////////////////////////////////////

`default_nettype none

module aes_sbox (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // Shift-and-add multiply, reduction comes from the package helper
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] shf;
    acc = 8'h00;
    shf = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ shf;
      end
      shf = aes_pkg::aes_mul2(shf);
    end
    return acc;
  endfunction

  ////////////////////////////////////////////////////////////
  // Inverse as x^254
  ////////////////////////////////////////////////////////////

  // Exponent of each partial product is in the name
  logic [7:0] x2, x3, x6, x7, x14, x15;
  logic [7:0] x30, x31, x62, x63, x126, x127;
  logic [7:0] inv;

  // Alternate squaring and multiplying by x
  assign x2   = gf_mul(data_i, data_i);
  assign x3   = gf_mul(x2, data_i);
  assign x6   = gf_mul(x3, x3);
  assign x7   = gf_mul(x6, data_i);
  assign x14  = gf_mul(x7, x7);
  assign x15  = gf_mul(x14, data_i);
  assign x30  = gf_mul(x15, x15);
  assign x31  = gf_mul(x30, data_i);
  assign x62  = gf_mul(x31, x31);
  assign x63  = gf_mul(x62, data_i);
  assign x126 = gf_mul(x63, x63);
  assign x127 = gf_mul(x126, data_i);

  // Final square, zero input gives zero here as required
  assign inv = gf_mul(x127, x127);

  ////////////////////////////////////////////////////////////
  // Affine transform
  ////////////////////////////////////////////////////////////

  // XOR of the inverse with its left rotations by 1 to 4
  // plus the constant 0x63
  assign data_o = inv
                ^ {inv[6:0], inv[7]}
                ^ {inv[5:0], inv[7:6]}
                ^ {inv[4:0], inv[7:5]}
                ^ {inv[3:0], inv[7:4]}
                ^ 8'h63;

endmodule

`default_nettype wire

//--- tests/tb_aes_key_expand.sv
////////////////////////////////////////////////////////////
// Testbench for the AES key expansion step
// LFSR stimulus, FIPS-197 step model with its own S-box
// Forward and inverse chains, random steps, back-pressure
////////////////////////////////////////////////////////////

`default_nettype none

module tb_aes_key_expand;

  timeunit 1ns;
  timeprecision 100ps;

  // Reset and the four chains take under 80 cycles on top of the random steps
  localparam int RandCycles    = 420;
  localparam int TestCycles    = RandCycles + 80;
  localparam int TimeoutCycles = 4 * TestCycles;

  logic                clk;
  logic                rst_n;
  aes_pkg::key_cfg_t   cfg_in;
  aes_pkg::key_state_t key_in;
  aes_pkg::key_state_t key_out;
  logic                clear;
  logic                en;
  logic                out_ack;
  logic                out_req;

  logic [7:0]  sbox_tab [256];
  logic [7:0]  m_rcon;
  logic [31:0] lfsr;
  int          key_errs;
  int          req_errs;
  int          end_errs;
  int          checks;
  int          cycles = 0;

  tb_clk_gen u_tb_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  aes_key_expand u_aes_key_expand (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .cfg_i     (cfg_in),
    .clear_i   (clear),
    .en_i      (en),
    .out_ack_i (out_ack),
    .key_i     (key_in),
    .out_req_o (out_req),
    .key_o     (key_out)
  );

  ////////////////////////////////////////////////////////////
  // Reference arithmetic and S-box
  ////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] gf_xtime(input logic [7:0] a);
    logic [8:0] t;
    t = {a, 1'b0};
    if (t[8]) t = t ^ 9'h11b;
    return t[7:0];
  endfunction

  // Odd values had the polynomial folded in and get it removed first
  function automatic logic [7:0] gf_half(input logic [7:0] a);
    logic [8:0] t;
    t = {1'b0, a};
    if (a[0]) t = t ^ 9'h11b;
    return t[8:1];
  endfunction

  function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ a;
      a = gf_xtime(a);
    end
    return p;
  endfunction

  // Inverse by search followed by the FIPS-197 bitwise affine map
  task automatic build_sbox();
    logic [7:0] inv;
    logic [7:0] s;
    logic [7:0] c;
    c = 8'h63;
    for (int x = 0; x < 256; x++) begin
      inv = 8'h00;
      for (int y = 1; y < 256; y++) begin
        if (gf_mult(x[7:0], y[7:0]) == 8'h01) inv = y[7:0];
      end
      for (int i = 0; i < 8; i++) begin
        s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
             ^ inv[(i + 7) % 8] ^ c[i];
      end
      sbox_tab[x] = s;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Key schedule model
  ////////////////////////////////////////////////////////////

  // Even AES-256 rounds go without RotWord and Rcon
  function automatic logic rcon_used(input aes_pkg::key_cfg_t cfg);
    return !(cfg.key_len == aes_pkg::AES_256 && cfg.round[0] == 1'b0);
  endfunction

  function automatic logic [7:0] rcon_start(input aes_pkg::key_cfg_t cfg);
    if (cfg.op == aes_pkg::CIPH_FWD) return 8'h01;
    return (cfg.key_len == aes_pkg::AES_128) ? 8'h36 : 8'h40;
  endfunction

  function automatic aes_pkg::key_state_t next_key_model(input aes_pkg::key_cfg_t cfg,
                                                         input aes_pkg::key_state_t k,
                                                         input logic [7:0] rc);
    aes_pkg::word_t      t;
    aes_pkg::word_t      n;
    aes_pkg::key_state_t o;
    logic                fwd;
    logic                use_rc;
    int                  src;
    fwd    = (cfg.op == aes_pkg::CIPH_FWD);
    use_rc = rcon_used(cfg);
    // Word that feeds RotWord and SubWord
    if (cfg.key_len == aes_pkg::AES_128) begin
      t = fwd ? k[3] : (k[3] ^ k[2]);
    end else begin
      t = fwd ? k[7] : k[3];
    end
    for (int j = 0; j < 4; j++) begin
      src  = use_rc ? (j + 1) % 4 : j;
      n[j] = sbox_tab[t[src]];
    end
    if (use_rc) n[0] = n[0] ^ rc;
    o = k;
    if (cfg.key_len == aes_pkg::AES_128) begin
      o[7:4] = k[3:0];
      o[0]   = n ^ k[0];
      for (int i = 1; i < 4; i++) begin
        o[i] = fwd ? (o[i-1] ^ k[i]) : (k[i-1] ^ k[i]);
      end
    end else if (cfg.round == 4'd0) begin
      o = {k[3:0], k[7:4]};
    end else if (fwd) begin
      o[3:0] = k[7:4];
      o[4]   = n ^ k[0];
      for (int i = 5; i < 8; i++) o[i] = o[i-1] ^ k[i-4];
    end else begin
      o[7:4] = k[3:0];
      o[0]   = n ^ k[4];
      for (int i = 1; i < 4; i++) o[i] = k[i+3] ^ k[i+4];
    end
    return o;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////////////////////////

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic random_key(output aes_pkg::key_state_t k);
    logic [31:0] v;
    for (int w = 0; w < 8; w++) begin
      take_bits(32, v);
      k[w] = v;
    end
  endtask

  // FIPS-197 writes the first byte leftmost while byte 0 sits low here
  function automatic aes_pkg::word_t fips_word(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Drives one cycle and checks it at the falling edge
  // Model Rcon then follows the handshake
  task automatic drive_and_check(input aes_pkg::key_cfg_t cfg, input aes_pkg::key_state_t key,
                                 input logic clr, input logic en_v, input logic ack_v,
                                 output aes_pkg::key_state_t got);
    aes_pkg::key_state_t exp;
    @(posedge clk);
    cfg_in  <= cfg;
    key_in  <= key;
    clear   <= clr;
    en      <= en_v;
    out_ack <= ack_v;
    @(negedge clk);
    exp    = next_key_model(cfg, key, m_rcon);
    got    = key_out;
    checks = checks + 1;
    assert (key_out === exp) else begin
      key_errs++;
      $display("ERR %0t key_o exp %h got %h", $time, exp, key_out);
    end
    assert (out_req === en_v) else begin
      req_errs++;
      $display("ERR %0t out_req_o exp %b got %b", $time, en_v, out_req);
    end
    if (clr) begin
      m_rcon = rcon_start(cfg);
    end else if (en_v && ack_v && rcon_used(cfg)) begin
      m_rcon = (cfg.op == aes_pkg::CIPH_FWD) ? gf_xtime(m_rcon) : gf_half(m_rcon);
    end
  endtask

  // Clear and then step through the rounds from first to last
  task automatic run_chain(input aes_pkg::ciph_op_e op, input aes_pkg::key_len_e len,
                           input int first, input int last,
                           inout aes_pkg::key_state_t key);
    aes_pkg::key_cfg_t   cfg;
    aes_pkg::key_state_t got;
    int                  dir;
    cfg.op      = op;
    cfg.key_len = len;
    cfg.round   = 4'(first);
    dir         = (last >= first) ? 1 : -1;
    drive_and_check(cfg, key, 1'b1, 1'b0, 1'b0, got);
    for (int n = 0; n <= (last - first) * dir; n++) begin
      cfg.round = 4'(first + n * dir);
      drive_and_check(cfg, key, 1'b0, 1'b1, 1'b1, got);
      key = got;
    end
  endtask

  task automatic report_counts();
    $display("Errors: key_o %0d, out_req_o %0d, chain end %0d, after %0d checks",
             key_errs, req_errs, end_errs, checks);
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      report_counts();
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    aes_pkg::key_state_t orig;
    aes_pkg::key_state_t key;
    aes_pkg::key_state_t got;
    aes_pkg::key_state_t r10;
    aes_pkg::key_cfg_t   cfg;
    logic [31:0]         bits;
    logic                ack_v;
    int                  stall;
    cfg_in   = '0;
    key_in   = '0;
    clear    = 1'b0;
    en       = 1'b0;
    out_ack  = 1'b0;
    lfsr     = 32'hf9dafde5;
    m_rcon   = 8'h00;
    key_errs = 0;
    req_errs = 0;
    end_errs = 0;
    checks   = 0;
    build_sbox();

    // Request stays low during reset while en is low
    @(negedge clk);
    assert (out_req === 1'b0) else begin
      req_errs++;
      $display("ERR %0t out_req_o exp 0 got %b during reset", $time, out_req);
    end
    wait (rst_n === 1'b1);
    for (int n = 0; n < 4; n++) begin
      take_bits(6, bits);
      random_key(key);
      drive_and_check(aes_pkg::key_cfg_t'(bits[5:0]), key, 1'b0, 1'b0, bits[0], got);
    end

    // AES-128 forward from the FIPS-197 cipher key and back again
    random_key(orig);
    orig[0] = fips_word(32'h2b7e1516);
    orig[1] = fips_word(32'h28aed2a6);
    orig[2] = fips_word(32'habf71588);
    orig[3] = fips_word(32'h09cf4f3c);
    r10[0]  = fips_word(32'hd014f9a8);
    r10[1]  = fips_word(32'hc9ee2589);
    r10[2]  = fips_word(32'he13f0cc8);
    r10[3]  = fips_word(32'hb6630ca6);
    key = orig;
    run_chain(aes_pkg::CIPH_FWD, aes_pkg::AES_128, 1, 10, key);
    assert (key[3:0] === r10[3:0]) else begin
      end_errs++;
      $display("ERR %0t key_o round 10 exp %h got %h", $time, r10[3:0], key[3:0]);
    end
    run_chain(aes_pkg::CIPH_INV, aes_pkg::AES_128, 10, 1, key);
    assert (key[3:0] === orig[3:0]) else begin
      end_errs++;
      $display("ERR %0t key_o inverse end exp %h got %h", $time, orig[3:0], key[3:0]);
    end

    // AES-256 with the round 0 half swap at both ends
    random_key(orig);
    key = orig;
    run_chain(aes_pkg::CIPH_FWD, aes_pkg::AES_256, 0, 13, key);
    run_chain(aes_pkg::CIPH_INV, aes_pkg::AES_256, 13, 0, key);
    assert (key === orig) else begin
      end_errs++;
      $display("ERR %0t key_o AES-256 inverse end exp %h got %h", $time, orig, key);
    end

    // Random single steps with stretches of withheld acknowledge
    stall = 0;
    for (int n = 0; n < RandCycles; n++) begin
      take_bits(6, bits);
      cfg = aes_pkg::key_cfg_t'(bits[5:0]);
      random_key(key);
      if (stall > 0) begin
        stall--;
        ack_v = 1'b0;
      end else begin
        take_bits(4, bits);
        if (bits[3:0] == 4'd0) begin
          take_bits(3, bits);
          stall = bits[2:0];
          ack_v = 1'b0;
        end else begin
          ack_v = |bits[1:0];
        end
      end
      take_bits(5, bits);
      drive_and_check(cfg, key, bits[4:2] == 3'd0, |bits[1:0], ack_v, got);
    end

    report_counts();
    if (key_errs + req_errs + end_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset source
// 4 ns clock, active-low reset held for 3 cycles
////////////////////////////////////////////////////////////

`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock, 2 ns per phase
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release reset after the third rising edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire
